/* periph_trace.txt */
# cmd  addr-or-key  data-or-expected, all hex
# W write, R read, P/U press/release key, Q poll reg, I poll irq {key,timer}, L led, S hold
L 0 0
I 0 0
R 1000 0
R 2000 0
R 2004 0
R 2008 0
R 200C 0
R 3000 0
R 3004 0
R 3008 0
R 300C 0
W 1000 A5
L 0 A5
R 1000 A5
R 0000 0
R 5000 0
P 9 0
Q 2004 200
P 2 0
Q 2004 204
U 9 0
U 2 0
Q 2004 0
Q 2000 0
W 2008 F
R 2008 0
W 200C 4
P 2 0
Q 2000 4
I 0 8
W 2008 4
I 0 0
P 1 0
Q 2000 6
Q 2008 2
I 0 0
U 1 0
U 2 0
Q 2000 0
W 3008 1E
W 3000 3
I 0 1
R 300C 1
W 300C 1
I 0 0
W 3000 1
Q 300C 1
I 0 0
W 3000 0
S 3004 A

/* src.f */
+incdir+.
periph_pkg.sv
apb_slave_mux.sv
apb_led.sv
keypad_scan.sv
key_filter.sv
apb_key.sv
apb_timer.sv
periph_top.sv
periph_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; fails when the log holds the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/10ps -f src.f \
    --top-module periph_tb > build.log 2>&1 &&
./obj_dir/Vperiph_tb > sim.log 2>&1 || { echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation failed"; exit 1; } || exit 0

/* periph_tb.sv */
// Testbench for the APB peripheral subsystem. Acts as the APB master, models
// the keypad matrix and plays the command trace in periph_trace.txt.
// Every check prints one line; the run closes with the counts.

`timescale 1ns/10ps

`include "periph_defines.svh"

module periph_tb import periph_pkg::*; ();

    localparam int SCAN_PERIOD = `KEY_ROWS * `SCAN_HOLD_CYCLES;
    localparam int KEY_WAIT    = 4 * `SCAN_HOLD_CYCLES + `DEBOUNCE_CYCLES + 100;

    logic                           clk = 1'b0;
    logic                           RSTn;
    logic                           psel;
    apb_req_t                       req;
    apb_rsp_t                       rsp;
    logic [`KEY_COLS-1:0]           col;
    logic [`KEY_ROWS-1:0]           row;
    logic [`LED_W-1:0]              led;
    irq_t                           irq;
    logic [`KEY_ROWS*`KEY_COLS-1:0] pressed;    // Keys held down by the model
    int                             n_checks = 0;
    int                             n_errors = 0;
    int                             last_reload = 0;

    always #20 clk = ~clk;

    periph_top periph_top_i (
        .clk(clk), .RSTn(RSTn), .psel(psel), .req(req), .rsp(rsp),
        .col(col), .row(row), .led(led), .irq(irq)
    );

    // Keypad matrix, a pressed key shorts its column to a low row
    always_comb begin
        col = '1;
        for (int r = 0; r < `KEY_ROWS; r++)
            for (int c = 0; c < `KEY_COLS; c++)
                if (!row[r] && pressed[r*`KEY_COLS+c])
                    col[c] = 1'b0;
    end

    // Row pattern with only row r driven low
    function automatic logic [`KEY_ROWS-1:0] row_low(input int r);
        logic [`KEY_ROWS-1:0] pat;
        pat    = '1;
        pat[r] = 1'b0;
        return pat;
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_data(input string name, input logic [`APB_DATA_W-1:0] exp,
                              input logic [`APB_DATA_W-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end else
            $display("Ok %s = %h", name, act);
    endtask

    task automatic check_irq(input irq_t exp, input irq_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error at %0t ns: irq expected %h, got %h", $time, exp, act);
        end else
            $display("Ok irq = %h", act);
    endtask

    task automatic check_led(input logic [`LED_W-1:0] exp, input logic [`LED_W-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error at %0t ns: led expected %h, got %h", $time, exp, act);
        end else
            $display("Ok led = %h", act);
    endtask

    task automatic check_row(input logic [`KEY_ROWS-1:0] exp,
                             input logic [`KEY_ROWS-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error at %0t ns: row expected %b, got %b", $time, exp, act);
        end else
            $display("Ok row = %b", act);
    endtask

    // Only ready and slverr are compared
    task automatic check_rsp(input apb_rsp_t exp, input apb_rsp_t act);
        n_checks++;
        if ({act.ready, act.slverr} !== {exp.ready, exp.slverr}) begin
            n_errors++;
            $display("Error at %0t ns: rsp.ready/slverr expected %b%b, got %b%b",
                     $time, exp.ready, exp.slverr, act.ready, act.slverr);
        end else
            $display("Ok rsp ready=%b slverr=%b", act.ready, act.slverr);
    endtask

    // ------------------------------------------------------------------------
    // APB master and keypad stimulus
    // ------------------------------------------------------------------------
    task automatic after_edge();
        @(posedge clk);
        #2;
    endtask

    // Row 0 low out of reset, row 1 low after one hold
    task automatic scan_start_rows();
        @(negedge clk);
        check_row(row_low(0), row);
        repeat (`SCAN_HOLD_CYCLES) @(negedge clk);
        check_row(row_low(1), row);
    endtask

    // Setup, access, then one idle cycle; 3 clocks in all
    task automatic apb_access(input logic wr, input logic [`APB_ADDR_W-1:0] adr,
                              input logic [`APB_DATA_W-1:0] wd, input bit chk,
                              output logic [`APB_DATA_W-1:0] rd);
        apb_rsp_t exp_rsp;
        exp_rsp = '{rdata: '0, ready: 1'b1, slverr: 1'b0};
        after_edge();
        psel = 1'b1;
        req  = '{addr: adr, write: wr, enable: 1'b0, wdata: wd};
        after_edge();
        req.enable = 1'b1;
        @(negedge clk);                     // Access phase, data settled
        rd = rsp.rdata;
        if (chk)
            check_rsp(exp_rsp, rsp);
        after_edge();                       // Write lands on this edge
        psel       = 1'b0;
        req.enable = 1'b0;
        req.write  = 1'b0;
    endtask

    task automatic poll_reg(input logic [`APB_ADDR_W-1:0] adr,
                            input logic [`APB_DATA_W-1:0] exp);
        logic [`APB_DATA_W-1:0] rd;
        int                     limit;
        int                     waited;
        limit  = (adr[`SLOT_MSB:`SLOT_LSB] == SLOT_TIMER) ? last_reload + 20 : KEY_WAIT;
        waited = 0;
        apb_access(1'b0, adr, '0, 1'b0, rd);
        while (rd !== exp && waited < limit) begin
            apb_access(1'b0, adr, '0, 1'b0, rd);
            waited += 3;
        end
        if (rd !== exp)
            $display("Timeout at %0t ns: register %h never read %h", $time, adr, exp);
        check_data($sformatf("poll rdata[%h]", adr), exp, rd);
    endtask

    task automatic poll_irq(input irq_t exp);
        int limit;
        int waited;
        limit  = exp.timer ? last_reload + 20 : KEY_WAIT;
        waited = 0;
        @(negedge clk);
        while (irq !== exp && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (irq !== exp)
            $display("Timeout at %0t ns: irq never reached %h", $time, exp);
        check_irq(exp, irq);
    endtask

    // Press with one bounce, each level held for a full scan
    task automatic press_key(input int k);
        after_edge();
        pressed[k] = 1'b1;
        repeat (SCAN_PERIOD) after_edge();
        pressed[k] = 1'b0;
        repeat (SCAN_PERIOD) after_edge();
        pressed[k] = 1'b1;
    endtask

    task automatic run_cmd(input byte cmd, input logic [31:0] a, input logic [31:0] d);
        logic [`APB_DATA_W-1:0] rd;
        logic [`APB_DATA_W-1:0] rd2;
        case (cmd)
            "W": begin
                if (a[`SLOT_MSB:`SLOT_LSB] == SLOT_TIMER && a[`SLOT_LSB-1:0] == TMR_RELOAD)
                    last_reload = int'(d);
                apb_access(1'b1, a[`APB_ADDR_W-1:0], d, 1'b1, rd);
            end
            "R": begin
                apb_access(1'b0, a[`APB_ADDR_W-1:0], '0, 1'b1, rd);
                check_data($sformatf("rdata[%h]", a[`APB_ADDR_W-1:0]), d, rd);
            end
            "P": press_key(int'(a));
            "U": begin
                after_edge();
                pressed[a] = 1'b0;
            end
            "Q": poll_reg(a[`APB_ADDR_W-1:0], d);
            "I": poll_irq(irq_t'(d[`FILTERED_KEYS:0]));
            "L": begin
                @(negedge clk);
                check_led(d[`LED_W-1:0], led);
            end
            "S": begin                      // Register must hold over d cycles
                apb_access(1'b0, a[`APB_ADDR_W-1:0], '0, 1'b1, rd);
                repeat (int'(d)) after_edge();
                apb_access(1'b0, a[`APB_ADDR_W-1:0], '0, 1'b1, rd2);
                check_data($sformatf("held rdata[%h]", a[`APB_ADDR_W-1:0]), rd, rd2);
            end
            default: begin
                n_errors++;
                $display("Unknown trace command %c", cmd);
            end
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Trace player
    // ------------------------------------------------------------------------
    initial begin
        string       line;
        byte         cmd;
        logic [31:0] a;
        logic [31:0] d;
        int          fd;
        int          n;
        RSTn    = 1'b0;
        psel    = 1'b0;
        req     = '0;
        pressed = '0;
        repeat (10) @(posedge clk);
        #2 RSTn = 1'b1;
        scan_start_rows();
        fd = $fopen("periph_trace.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("Trace file periph_trace.txt could not be opened");
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%c %h %h", cmd, a, d);
                if (n == 3 && cmd != "#")   // Skip comments and blank lines
                    run_cmd(cmd, a, d);
            end
            $fclose(fd);
        end
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0 && n_checks > 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* periph_top.sv */
// Top of the APB peripheral subsystem. An external APB master drives psel
// and req; the slot decoder routes them to the LED, key and timer slaves.
// The keypad scanner and four debounce filters feed the key port.

`timescale 1ns/10ps

`include "periph_defines.svh"

module periph_top import periph_pkg::*; (
    input  logic                 clk,
    input  logic                 RSTn,
    input  logic                 psel,
    input  apb_req_t             req,
    output apb_rsp_t             rsp,
    input  logic [`KEY_COLS-1:0] col,
    output logic [`KEY_ROWS-1:0] row,
    output logic [`LED_W-1:0]    led,
    output irq_t                 irq
);

    logic                           led_sel;
    logic                           key_sel;
    logic                           timer_sel;
    apb_rsp_t                       led_rsp;
    apb_rsp_t                       key_rsp;
    apb_rsp_t                       timer_rsp;
    logic [`KEY_ROWS*`KEY_COLS-1:0] key_raw;
    logic [`FILTERED_KEYS-1:0]      key_filt;
    logic [`FILTERED_KEYS-1:0]      key_irq;
    logic                           timer_irq;

    // ------------------------------------------------------------------------
    // APB decode and slaves
    // ------------------------------------------------------------------------
    apb_slave_mux apb_slave_mux_i (
        .psel(psel), .addr(req.addr),
        .led_rsp(led_rsp), .key_rsp(key_rsp), .timer_rsp(timer_rsp),
        .led_sel(led_sel), .key_sel(key_sel), .timer_sel(timer_sel),
        .rsp(rsp)
    );

    apb_led apb_led_i (
        .clk(clk), .RSTn(RSTn), .sel(led_sel), .req(req), .rsp(led_rsp), .led(led)
    );

    apb_key apb_key_i (
        .clk(clk), .RSTn(RSTn), .sel(key_sel), .req(req), .rsp(key_rsp),
        .key_raw(key_raw), .key_filt(key_filt), .key_irq(key_irq)
    );

    apb_timer apb_timer_i (
        .clk(clk), .RSTn(RSTn), .sel(timer_sel), .req(req), .rsp(timer_rsp),
        .timer_irq(timer_irq)
    );

    // ------------------------------------------------------------------------
    // Keypad front end
    // ------------------------------------------------------------------------
    keypad_scan keypad_scan_i (
        .clk(clk), .RSTn(RSTn), .col(col), .row(row), .key_raw(key_raw)
    );

    // Only the first keys of row 0 get debounced
    for (genvar k = 0; k < `FILTERED_KEYS; k++) begin : g_filter
        key_filter key_filter_i (
            .clk(clk), .RSTn(RSTn), .key_in(key_raw[k]), .key_out(key_filt[k])
        );
    end

    assign irq = '{key: key_irq, timer: timer_irq};

endmodule

/* apb_timer.sv */
// Down-counting timer on the APB. CTRL bit 0 runs the count, bit 1 lets the
// status reach timer_irq. At zero the counter reloads and sets status, which
// clears on a write of 1. Writing RELOAD also restarts the count from it.

`timescale 1ns/10ps

`include "periph_defines.svh"

module apb_timer import periph_pkg::*; (
    input  logic     clk,
    input  logic     RSTn,
    input  logic     sel,
    input  apb_req_t req,
    output apb_rsp_t rsp,
    output logic     timer_irq
);

    timer_reg_e           reg_off;
    logic                 wr_en;
    logic                 rd_en;
    logic [1:0]           ctrl;          // [0] count enable, [1] irq enable
    logic [`TIMER_W-1:0]  value;
    logic [`TIMER_W-1:0]  reload;
    logic                 int_stat;
    logic                 reload_hit;
    logic                 value_wr;
    logic                 stat_clr;

    assign reg_off    = timer_reg_e'({req.addr[`SLOT_LSB-1:2], 2'b00});
    assign wr_en      = sel && req.enable && req.write;
    assign rd_en      = sel && !req.write;
    assign reload_hit = ctrl[0] && (value == '0);
    assign value_wr   = wr_en && (reg_off == TMR_VALUE || reg_off == TMR_RELOAD);
    assign stat_clr   = wr_en && (reg_off == TMR_INTSTAT) && req.wdata[0];

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            ctrl     <= '0;
            value    <= '0;
            reload   <= '0;
            int_stat <= 1'b0;
        end else begin
            if (wr_en && reg_off == TMR_CTRL)
                ctrl <= req.wdata[1:0];
            if (wr_en && reg_off == TMR_RELOAD)
                reload <= req.wdata[`TIMER_W-1:0];
            // Bus write overrides the count for one cycle
            if (value_wr)
                value <= req.wdata[`TIMER_W-1:0];
            else if (reload_hit)
                value <= reload;
            else if (ctrl[0])
                value <= value - 1'b1;
            int_stat <= (int_stat && !stat_clr) || reload_hit;
        end
    end

    assign timer_irq = int_stat && ctrl[1];

    always_comb begin
        rsp       = '0;
        rsp.ready = 1'b1;
        if (rd_en) begin
            case (reg_off)
                TMR_CTRL:    rsp.rdata[1:0] = ctrl;
                TMR_VALUE:   rsp.rdata[`TIMER_W-1:0] = value;
                TMR_RELOAD:  rsp.rdata[`TIMER_W-1:0] = reload;
                TMR_INTSTAT: rsp.rdata[0] = int_stat;
                default:     rsp.rdata = '0;
            endcase
        end
    end

endmodule

/* apb_key.sv */
// Key port on the APB. Reports the debounced keys, the raw scan image and a
// per-key interrupt status set on each press of a filtered key. Status bits
// clear when 1 is written; key_irq is status masked by the enable register.

`timescale 1ns/10ps

`include "periph_defines.svh"

module apb_key import periph_pkg::*; (
    input  logic                           clk,
    input  logic                           RSTn,
    input  logic                           sel,
    input  apb_req_t                       req,
    output apb_rsp_t                       rsp,
    input  logic [`KEY_ROWS*`KEY_COLS-1:0] key_raw,
    input  logic [`FILTERED_KEYS-1:0]      key_filt,
    output logic [`FILTERED_KEYS-1:0]      key_irq
);

    localparam int FK = `FILTERED_KEYS;

    key_reg_e      reg_off;
    logic          wr_en;
    logic          rd_en;
    logic [FK-1:0] filt_q;               // Last cycle's filtered keys
    logic [FK-1:0] key_rise;
    logic [FK-1:0] stat_clr;
    logic [FK-1:0] int_stat;
    logic [FK-1:0] int_en;

    assign reg_off  = key_reg_e'({req.addr[`SLOT_LSB-1:2], 2'b00});
    assign wr_en    = sel && req.enable && req.write;
    assign rd_en    = sel && !req.write;
    assign key_rise = key_filt & ~filt_q;
    assign stat_clr = (wr_en && reg_off == KEY_INTSTAT) ? req.wdata[FK-1:0] : '0;

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            filt_q   <= '0;
            int_stat <= '0;
            int_en   <= '0;
        end else begin
            filt_q   <= key_filt;
            int_stat <= (int_stat & ~stat_clr) | key_rise;  // New press wins
            if (wr_en && reg_off == KEY_INTEN)
                int_en <= req.wdata[FK-1:0];
        end
    end

    assign key_irq = int_stat & int_en;

    always_comb begin
        rsp       = '0;
        rsp.ready = 1'b1;
        if (rd_en) begin
            case (reg_off)
                KEY_STATE:   rsp.rdata[FK-1:0] = key_filt;
                KEY_RAW:     rsp.rdata[`KEY_ROWS*`KEY_COLS-1:0] = key_raw;
                KEY_INTSTAT: rsp.rdata[FK-1:0] = int_stat;
                KEY_INTEN:   rsp.rdata[FK-1:0] = int_en;
                default:     rsp.rdata = '0;
            endcase
        end
    end

endmodule

/* key_filter.sv */
// Debounce filter for one key. The output follows the input only after the
// input has differed from it for SETTLE_CYCLES cycles in a row; any bounce
// back to the old level restarts the wait.

`timescale 1ns/10ps

`include "periph_defines.svh"

module key_filter import periph_pkg::*; #(
    parameter int SETTLE_CYCLES = `DEBOUNCE_CYCLES
) (
    input  logic clk,
    input  logic RSTn,
    input  logic key_in,
    output logic key_out
);

    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    kf_state_e        state;
    logic [CNT_W-1:0] settle_cnt;

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state      <= KF_STABLE;
            settle_cnt <= '0;
            key_out    <= 1'b0;
        end else begin
            case (state)
                KF_STABLE: begin
                    if (key_in != key_out) begin
                        state      <= KF_SETTLE;
                        settle_cnt <= CNT_W'(1);    // First differing cycle
                    end
                end
                KF_SETTLE: begin
                    if (key_in == key_out) begin    // Bounce
                        state      <= KF_STABLE;
                        settle_cnt <= '0;
                    end else if (settle_cnt >= CNT_W'(SETTLE_CYCLES - 1)) begin
                        state      <= KF_STABLE;
                        settle_cnt <= '0;
                        key_out    <= key_in;       // Commit new level
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                default: state <= KF_STABLE;
            endcase
        end
    end

endmodule

/* keypad_scan.sv */
// Row scanner for the keypad matrix. Drives one row low at a time, holds it
// for HOLD_CYCLES and samples the columns on the last cycle of the hold.
// key_raw has bit row*KEY_COLS+col set while that key is pressed.

`timescale 1ns/10ps

`include "periph_defines.svh"

module keypad_scan #(
    parameter int HOLD_CYCLES = `SCAN_HOLD_CYCLES
) (
    input  logic                              clk,
    input  logic                              RSTn,
    input  logic [`KEY_COLS-1:0]              col,
    output logic [`KEY_ROWS-1:0]              row,
    output logic [`KEY_ROWS*`KEY_COLS-1:0]    key_raw
);

    localparam int ROWS  = `KEY_ROWS;
    localparam int COLS  = `KEY_COLS;
    localparam int CNT_W = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES) : 1;
    localparam int IDX_W = (ROWS > 1) ? $clog2(ROWS) : 1;

    logic [CNT_W-1:0] hold_cnt;
    logic [IDX_W-1:0] row_idx;
    logic             hold_end;

    assign hold_end = (hold_cnt == CNT_W'(HOLD_CYCLES - 1));

    // ------------------------------------------------------------------------
    // Row rotation
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            hold_cnt <= '0;
            row_idx  <= '0;
            row      <= {{(ROWS-1){1'b1}}, 1'b0};     // Row 0 low
        end else if (hold_end) begin
            hold_cnt <= '0;
            row      <= {row[ROWS-2:0], row[ROWS-1]};  // Low bit moves up
            if (row_idx == IDX_W'(ROWS - 1))
                row_idx <= '0;
            else
                row_idx <= row_idx + 1'b1;
        end else begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Column capture
    // ------------------------------------------------------------------------
    // Pressed key pulls its column low while its row is driven low
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            key_raw <= '0;
        end else if (hold_end) begin
            key_raw[row_idx*COLS +: COLS] <= ~col;
        end
    end

endmodule

/* apb_led.sv */
// LED output port on the APB. One register at offset 0 drives the LED pins
// and reads back; every other offset in the slot reads as zero.

`timescale 1ns/10ps

`include "periph_defines.svh"

module apb_led import periph_pkg::*; (
    input  logic              clk,
    input  logic              RSTn,
    input  logic              sel,
    input  apb_req_t          req,
    output apb_rsp_t          rsp,
    output logic [`LED_W-1:0] led
);

    logic wr_en;
    logic rd_en;
    logic at_zero;

    assign wr_en   = sel && req.enable && req.write;  // Access phase
    assign rd_en   = sel && !req.write;
    assign at_zero = (req.addr[`SLOT_LSB-1:2] == '0);

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            led <= '0;
        end else if (wr_en && at_zero) begin
            led <= req.wdata[`LED_W-1:0];
        end
    end

    always_comb begin
        rsp       = '0;
        rsp.ready = 1'b1;
        if (rd_en && at_zero)
            rsp.rdata[`LED_W-1:0] = led;
    end

endmodule

/* apb_slave_mux.sv */
// APB slot decoder. Picks one slave from the upper address nibble, gates its
// select with psel and returns that slave's response to the master.
// Unmapped slots answer with zero data, ready high and no error.

`timescale 1ns/10ps

`include "periph_defines.svh"

module apb_slave_mux import periph_pkg::*; (
    input  logic                   psel,
    input  logic [`APB_ADDR_W-1:0] addr,
    input  apb_rsp_t               led_rsp,
    input  apb_rsp_t               key_rsp,
    input  apb_rsp_t               timer_rsp,
    output logic                   led_sel,
    output logic                   key_sel,
    output logic                   timer_sel,
    output apb_rsp_t               rsp
);

    apb_slot_e slot;

    assign slot = apb_slot_e'(addr[`SLOT_MSB:`SLOT_LSB]);

    // One select per mapped slot
    assign led_sel   = psel && (slot == SLOT_LED);
    assign key_sel   = psel && (slot == SLOT_KEY);
    assign timer_sel = psel && (slot == SLOT_TIMER);

    // Response return path
    always_comb begin
        rsp        = '0;
        rsp.ready  = 1'b1;               // Default slave, never stalls
        case (slot)
            SLOT_LED:   rsp = led_rsp;
            SLOT_KEY:   rsp = key_rsp;
            SLOT_TIMER: rsp = timer_rsp;
            default: begin
                rsp.rdata  = '0;
                rsp.slverr = 1'b0;
            end
        endcase
    end

endmodule

/* periph_pkg.sv */
// Shared types of the APB peripheral subsystem: bus request and response,
// slot numbers, register offsets, debounce states and the interrupt bundle.
// Modules pull this in with a wildcard import in their header.

`include "periph_defines.svh"

package periph_pkg;

    // Request fields seen by every slave
    typedef struct packed {
        logic [`APB_ADDR_W-1:0] addr;
        logic                   write;
        logic                   enable;
        logic [`APB_DATA_W-1:0] wdata;
    } apb_req_t;

    typedef struct packed {
        logic [`APB_DATA_W-1:0] rdata;
        logic                   ready;
        logic                   slverr;
    } apb_rsp_t;

    // Slot 0 stays unmapped
    typedef enum logic [`SLOT_MSB-`SLOT_LSB:0] {
        SLOT_LED   = 1,
        SLOT_KEY   = 2,
        SLOT_TIMER = 3
    } apb_slot_e;

    // Byte offsets inside a 4 KB slot
    typedef enum logic [`SLOT_LSB-1:0] {
        KEY_STATE   = 'h0,
        KEY_RAW     = 'h4,
        KEY_INTSTAT = 'h8,
        KEY_INTEN   = 'hC
    } key_reg_e;

    typedef enum logic [`SLOT_LSB-1:0] {
        TMR_CTRL    = 'h0,
        TMR_VALUE   = 'h4,
        TMR_RELOAD  = 'h8,
        TMR_INTSTAT = 'hC
    } timer_reg_e;

    typedef enum logic {KF_STABLE, KF_SETTLE} kf_state_e;

    typedef struct packed {
        logic [`FILTERED_KEYS-1:0] key;
        logic                      timer;
    } irq_t;

endpackage

/* periph_defines.svh */
// Widths, address decode position and timing defaults for the APB peripheral
// subsystem. Include this in every file that sizes a port or a counter.
// The timing defaults are kept short for simulation and should be raised
// for a real board clock.

`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// APB bus
`define APB_ADDR_W 16
`define APB_DATA_W 32

// Slot decode on the upper address nibble
`define SLOT_MSB 15
`define SLOT_LSB 12

// LED port
`define LED_W 8

// Keypad matrix
`define KEY_ROWS      4
`define KEY_COLS      4
`define FILTERED_KEYS 4                 // Keys 0-3 only

// Timing, in clock cycles
`define SCAN_HOLD_CYCLES 8              // Per row low time
`define DEBOUNCE_CYCLES  64             // Stable time before a key commits

// Timer
`define TIMER_W 32

`endif
